/* p8e0_pkg.sv */
package p8e0_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Opcodes and pipeline transfer types.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [1:0] {
        OP_ADD = 2'd0,
        OP_SUB = 2'd1,
        OP_MUL = 2'd2
    } p8e0_op_e;

    typedef struct packed {
        p8e0_op_e   opcode;
        logic [7:0] a;
        logic [7:0] b;
    } p8e0_req_t;

    typedef struct packed {
        logic [7:0] z;
        logic       is_nar;
    } p8e0_rsp_t;

    localparam logic [7:0] P8_NAR    = 8'h80;
    localparam logic [7:0] P8_MAXPOS = 8'h7F; // 64.
    localparam logic [7:0] P8_MINPOS = 8'h01; // 1/64.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Posit helpers.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [7:0] p8_c2(input logic [7:0] x);
        return 8'(~x + 8'd1);
    endfunction

    // Positive non-zero posit in, {k[3:0], 1.fffffff} out.
    function automatic logic [11:0] p8_decode(input logic [7:0] p);
        logic              run_bit;
        logic [2:0]        run_len;
        logic [6:0]        frac;
        logic signed [3:0] k;
        run_bit = p[6];
        run_len = 3'd0;
        for (int i = 6; i >= 0; i--) begin
            if (p[i] == run_bit && int'(run_len) == 6 - i) begin
                run_len = 3'(7 - i);
            end
        end
        frac = p[6:0] << (4'(run_len) + 4'd1); // Drop regime and terminator.
        k    = run_bit ? $signed({1'b0, run_len}) - 4'sd1 : -$signed({1'b0, run_len});
        return {k, 1'b1, frac};
    endfunction

    // Hidden bit in frac[15], lowest bit carries sticky. Returns a positive pattern.
    function automatic logic [7:0] p8_encode(input logic signed [5:0] k,
                                             input logic [15:0]       frac);
        logic [3:0]  reg_len;
        logic [6:0]  reg_bits;
        logic [21:0] u;
        logic [6:0]  mag;
        logic        round_bit;
        logic        sticky;
        if (k > 6'sd5) begin
            return P8_MAXPOS;
        end
        if (k < -6'sd6) begin
            return P8_MINPOS;
        end
        if (k >= 6'sd0) begin
            reg_len  = 4'(k) + 4'd2;
            reg_bits = 7'((8'd1 << (k + 6'sd2)) - 8'd2); // Ones then a zero.
        end else begin
            reg_len  = 4'(6'sd1 - k);
            reg_bits = 7'd1;
        end
        u         = (22'(reg_bits) << 15) | 22'(frac[14:0]);
        mag       = 7'(u >> (reg_len + 4'd8));
        round_bit = u[reg_len + 4'd7];
        sticky    = (u & ((22'd1 << (reg_len + 4'd7)) - 22'd1)) != 22'd0;
        if (round_bit && (sticky || mag[0])) begin
            mag = mag + 7'd1;
        end
        return {1'b0, mag};
    endfunction

endpackage

/* p8e0_add.sv */
`timescale 1ns/1ps

module p8e0_add
    import p8e0_pkg::*;
(
    input  logic [7:0] a,
    input  logic [7:0] b,
    output logic [7:0] z,
    output logic       is_nar
);

    logic [7:0]        mag_a;
    logic [7:0]        mag_b;
    logic [7:0]        mag_big;
    logic [7:0]        mag_small;
    logic              sign_z;
    logic signed [3:0] k_big;
    logic signed [3:0] k_small;
    logic [7:0]        f_big;
    logic [7:0]        f_small;
    logic [3:0]        shift;
    logic [23:0]       big_w;
    logic [23:0]       small_w;
    logic [23:0]       sum;
    logic [4:0]        lead;
    logic [23:0]       norm;
    logic signed [5:0] k_z;
    logic [15:0]       frac_z;
    logic [7:0]        mag_z;

    assign mag_a = a[7] ? p8_c2(a) : a;
    assign mag_b = b[7] ? p8_c2(b) : b;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Align, add or subtract, normalize.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        // Positive patterns order like their values.
        if (mag_a >= mag_b) begin
            mag_big   = mag_a;
            mag_small = mag_b;
            sign_z    = a[7];
        end else begin
            mag_big   = mag_b;
            mag_small = mag_a;
            sign_z    = b[7];
        end

        {k_big, f_big}     = p8_decode(mag_big);
        {k_small, f_small} = p8_decode(mag_small);
        shift              = 4'(k_big - k_small); // At most 12.

        // Fifteen spare bits keep the aligned operand exact.
        big_w   = {1'b0, f_big, 15'd0};
        small_w = {1'b0, f_small, 15'd0} >> shift;
        sum     = (a[7] == b[7]) ? big_w + small_w : big_w - small_w;

        lead = 5'd0;
        for (int i = 0; i < 24; i++) begin
            if (sum[i]) begin
                lead = 5'(i);
            end
        end

        norm   = sum << (5'd23 - lead);
        frac_z = {norm[23:9], norm[8] | (|norm[7:0])}; // Sticky in bit 0.
        k_z    = 6'(k_big) + $signed({1'b0, lead}) - 6'sd22;
        mag_z  = p8_encode(k_z, frac_z);
    end

    always_comb begin
        if (a == P8_NAR || b == P8_NAR) begin
            z = P8_NAR;
        end else if (a == 8'd0) begin
            z = b;
        end else if (b == 8'd0) begin
            z = a;
        end else if (a[7] != b[7] && mag_a == mag_b) begin
            z = 8'd0; // Exact cancellation.
        end else begin
            z = sign_z ? p8_c2(mag_z) : mag_z;
        end
    end

    assign is_nar = (z == P8_NAR);

endmodule

/* p8e0_mul.sv */
`timescale 1ns/1ps

module p8e0_mul
    import p8e0_pkg::*;
(
    input  logic [7:0] a,
    input  logic [7:0] b,
    output logic [7:0] z
);

    logic              sign_z;
    logic [7:0]        mag_a;
    logic [7:0]        mag_b;
    logic signed [3:0] k_a;
    logic signed [3:0] k_b;
    logic [7:0]        f_a;
    logic [7:0]        f_b;
    logic [15:0]       prod;
    logic signed [5:0] k_z;
    logic [15:0]       frac_z;
    logic [7:0]        mag_z;

    assign sign_z = a[7] ^ b[7];
    assign mag_a  = a[7] ? p8_c2(a) : a;
    assign mag_b  = b[7] ? p8_c2(b) : b;

    always_comb begin
        {k_a, f_a} = p8_decode(mag_a);
        {k_b, f_b} = p8_decode(mag_b);
        prod       = f_a * f_b; // 2.14 fixed point, always exact.

        // Product lies in [1, 4).
        if (prod[15]) begin
            k_z    = 6'(k_a) + 6'(k_b) + 6'sd1;
            frac_z = prod;
        end else begin
            k_z    = 6'(k_a) + 6'(k_b);
            frac_z = {prod[14:0], 1'b0};
        end
        mag_z = p8_encode(k_z, frac_z);
    end

    always_comb begin
        if (a == P8_NAR || b == P8_NAR) begin
            z = P8_NAR;
        end else if (a == 8'd0 || b == 8'd0) begin
            z = 8'd0;
        end else begin
            z = sign_z ? p8_c2(mag_z) : mag_z;
        end
    end

endmodule

/* p8e0_alu.sv */
`timescale 1ns/1ps

module p8e0_alu
    import p8e0_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      req_valid,
    input  p8e0_req_t req,
    output logic      rsp_valid,
    output p8e0_rsp_t rsp
);

    logic       s1_valid;
    p8e0_req_t  s1_req;
    logic [7:0] add_z;
    logic       add_nar;
    logic [7:0] mul_z;
    p8e0_rsp_t  s2_sel;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stage 1. Capture the request.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            s1_req.opcode <= req.opcode;
            s1_req.a      <= req.a;
            // Subtract is add of -b. NaR negates to itself.
            s1_req.b      <= (req.opcode == OP_SUB) ? p8_c2(req.b) : req.b;
        end
    end

    p8e0_add add_i (
        .a      (s1_req.a),
        .b      (s1_req.b),
        .z      (add_z),
        .is_nar (add_nar)
    );

    p8e0_mul mul_i (
        .a (s1_req.a),
        .b (s1_req.b),
        .z (mul_z)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stage 2. Select and register the result.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        if (s1_req.opcode == OP_MUL) begin
            s2_sel.z      = mul_z;
            s2_sel.is_nar = (mul_z == P8_NAR);
        end else begin
            s2_sel.z      = add_z;
            s2_sel.is_nar = add_nar;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            rsp <= s2_sel;
        end
    end

endmodule

/* p8e0_axil_regs.sv */
`timescale 1ns/1ps

module p8e0_axil_regs
    import p8e0_pkg::*;
#(
    parameter int ADDR_W = 4
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic [ADDR_W-1:0] awaddr,
    input  logic              awvalid,
    output logic              awready,
    input  logic [31:0]       wdata,
    input  logic              wvalid,
    output logic              wready,
    output logic [1:0]        bresp,
    output logic              bvalid,
    input  logic              bready,
    input  logic [ADDR_W-1:0] araddr,
    input  logic              arvalid,
    output logic              arready,
    output logic [31:0]       rdata,
    output logic [1:0]        rresp,
    output logic              rvalid,
    input  logic              rready,
    output logic              req_valid,
    output p8e0_req_t         req,
    input  logic              rsp_valid,
    input  p8e0_rsp_t         rsp
);

    localparam logic [ADDR_W-1:0] REG_OPERANDS = 'h0;
    localparam logic [ADDR_W-1:0] REG_CTRL     = 'h4;
    localparam logic [ADDR_W-1:0] REG_STATUS   = 'h8;
    localparam logic [ADDR_W-1:0] REG_RESULT   = 'hC;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    logic        wr_en;
    logic        rd_en;
    logic        launch;
    logic [1:0]  inflight;
    logic [1:0]  inflight_nxt;
    logic        done;
    logic        busy;
    p8e0_rsp_t   result;
    logic [31:0] rd_data;
    logic [1:0]  rd_resp;

    assign wr_en  = awvalid && awready && wvalid && wready;
    assign rd_en  = arvalid && arready;
    assign launch = wr_en && (awaddr == REG_CTRL) && (wdata[1:0] != 2'd3);
    assign busy   = (inflight != 2'd0);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Write channels.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            bresp   <= RESP_OKAY;
        end else begin
            // One-cycle ready pulse, held off while a response waits.
            awready <= awvalid && wvalid && !bvalid && !awready;
            wready  <= awvalid && wvalid && !bvalid && !awready;
            if (wr_en) begin
                bvalid <= 1'b1;
                bresp  <= (awaddr == REG_OPERANDS || launch) ? RESP_OKAY : RESP_SLVERR;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    // Operands are kept directly in the request register.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            req       <= '0;
            req_valid <= 1'b0;
        end else begin
            req_valid <= launch;
            if (wr_en && awaddr == REG_OPERANDS) begin
                req.a <= wdata[7:0];
                req.b <= wdata[15:8];
            end
            if (launch) begin
                req.opcode <= p8e0_op_e'(wdata[1:0]);
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Status and result.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        inflight_nxt = inflight;
        if (launch) begin
            inflight_nxt = inflight_nxt + 2'd1;
        end
        if (rsp_valid) begin
            inflight_nxt = inflight_nxt - 2'd1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            inflight <= 2'd0;
            done     <= 1'b0;
            result   <= '0;
        end else begin
            inflight <= inflight_nxt;
            if (launch) begin
                done <= 1'b0;
            end else if (rsp_valid && inflight_nxt == 2'd0) begin
                done <= 1'b1; // Last one out.
            end
            if (rsp_valid) begin
                result <= rsp;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read channel.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        rd_data = 32'd0;
        rd_resp = RESP_OKAY;
        case (araddr)
            REG_OPERANDS: rd_data = {16'd0, req.b, req.a};
            REG_STATUS:   rd_data = {30'd0, busy, done};
            REG_RESULT:   rd_data = {23'd0, result.is_nar, result.z};
            default:      rd_resp = RESP_SLVERR; // CTRL is write-only.
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rdata   <= 32'd0;
            rresp   <= RESP_OKAY;
        end else begin
            arready <= arvalid && !rvalid && !arready;
            if (rd_en) begin
                rvalid <= 1'b1;
                rdata  <= rd_data;
                rresp  <= rd_resp;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

endmodule

/* p8e0_top.sv */
`timescale 1ns/1ps

module p8e0_top
    import p8e0_pkg::*;
#(
    parameter int ADDR_W = 4
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic [ADDR_W-1:0] awaddr,
    input  logic              awvalid,
    output logic              awready,
    input  logic [31:0]       wdata,
    input  logic              wvalid,
    output logic              wready,
    output logic [1:0]        bresp,
    output logic              bvalid,
    input  logic              bready,
    input  logic [ADDR_W-1:0] araddr,
    input  logic              arvalid,
    output logic              arready,
    output logic [31:0]       rdata,
    output logic [1:0]        rresp,
    output logic              rvalid,
    input  logic              rready
);

    logic      req_valid;
    p8e0_req_t req;
    logic      rsp_valid;
    p8e0_rsp_t rsp;

    p8e0_axil_regs #(
        .ADDR_W (ADDR_W)
    ) regs_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .awaddr    (awaddr),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wvalid    (wvalid),
        .wready    (wready),
        .bresp     (bresp),
        .bvalid    (bvalid),
        .bready    (bready),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata     (rdata),
        .rresp     (rresp),
        .rvalid    (rvalid),
        .rready    (rready),
        .req_valid (req_valid),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

    p8e0_alu alu_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .req_valid (req_valid),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

endmodule

/* p8e0_properties.sv */
`timescale 1ns/1ps

module p8e0_properties (
    input logic        clk,
    input logic        arst_n,
    input logic [1:0]  bresp,
    input logic        bvalid,
    input logic        bready,
    input logic [31:0] rdata,
    input logic [1:0]  rresp,
    input logic        rvalid,
    input logic        rready,
    input logic        req_valid,
    input logic        rsp_valid
);

    bit failed = 1'b0;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // AXI response stability under back-pressure.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assert property (@(posedge clk) disable iff (!arst_n)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else begin
            $error("bvalid or bresp changed while bready was low");
            failed = 1'b1;
        end

    assert property (@(posedge clk) disable iff (!arst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else begin
            $error("rvalid, rdata or rresp changed while rready was low");
            failed = 1'b1;
        end

    // Two-stage pipeline latency.
    assert property (@(posedge clk) disable iff (!arst_n) req_valid |-> ##2 rsp_valid)
        else begin
            $error("rsp_valid missing two cycles after req_valid");
            failed = 1'b1;
        end

    assert property (@(posedge clk) disable iff (!arst_n) rsp_valid |-> $past(req_valid, 2))
        else begin
            $error("rsp_valid without req_valid two cycles earlier");
            failed = 1'b1;
        end

endmodule

bind p8e0_axil_regs p8e0_properties props_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .bresp     (bresp),
    .bvalid    (bvalid),
    .bready    (bready),
    .rdata     (rdata),
    .rresp     (rresp),
    .rvalid    (rvalid),
    .rready    (rready),
    .req_valid (req_valid),
    .rsp_valid (rsp_valid)
);

/* tb_p8e0_top.sv */
`timescale 1ns/1ps

module tb_p8e0_top
    import p8e0_pkg::*;
;

    localparam logic [3:0] ADDR_OPERANDS = 4'h0;
    localparam logic [3:0] ADDR_CTRL     = 4'h4;
    localparam logic [3:0] ADDR_STATUS   = 4'h8;
    localparam logic [3:0] ADDR_RESULT   = 4'hC;
    localparam logic [1:0] OKAY          = 2'b00;
    localparam logic [1:0] SLVERR        = 2'b10;
    localparam logic [7:0] NAR           = 8'h80;
    localparam int N_DIR       = 24;
    localparam int N_RAND      = 300;
    localparam int N_CHECKED   = N_DIR + N_RAND + 1;
    localparam int CYCLE_LIMIT = 20 * N_CHECKED + 200;

    // Entries are {opcode, a, b}.
    localparam logic [17:0] DIRECTED [N_DIR] = '{
        {2'd0, 8'h00, 8'h35}, {2'd0, 8'hC7, 8'h00}, {2'd1, 8'h00, 8'h35}, {2'd1, 8'h35, 8'h00},
        {2'd1, 8'h35, 8'h35}, {2'd1, 8'hC7, 8'hC7}, {2'd0, 8'h35, 8'hCB}, {2'd0, 8'h7F, 8'h7F},
        {2'd0, 8'h81, 8'h81}, {2'd1, 8'h01, 8'h02}, {2'd1, 8'h02, 8'h01}, {2'd1, 8'h01, 8'hFF},
        {2'd2, 8'h01, 8'h01}, {2'd2, 8'h7F, 8'h7F}, {2'd2, 8'h00, 8'h55}, {2'd0, 8'h80, 8'h35},
        {2'd0, 8'h35, 8'h80}, {2'd0, 8'h80, 8'h80}, {2'd1, 8'h80, 8'h35}, {2'd1, 8'h35, 8'h80},
        {2'd1, 8'h80, 8'h80}, {2'd2, 8'h80, 8'h35}, {2'd2, 8'h00, 8'h80}, {2'd2, 8'h80, 8'h80}
    };

    logic        clk;
    logic        arst_n;
    logic [3:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [3:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;

    logic [31:0] lfsr;
    int          cycles;
    int          checked;
    logic [31:0] got_q [$];
    logic [7:0]  exp_q [$];
    logic [17:0] tag_q [$];
    logic [31:0] got_word;
    logic [7:0]  exp_z;
    logic [17:0] tag;

    p8e0_top #(
        .ADDR_W (4)
    ) dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Value of a non-NaR posit times 2^12.
    function automatic longint posit_value(input logic [7:0] p);
        logic [7:0] m;
        int         n;
        int         i;
        int         k;
        int         nf;
        longint     f;
        longint     v;
        if (p == 8'h00) begin
            return 0;
        end
        m = p[7] ? 8'(~p + 8'd1) : p;
        n = 0;
        i = 6;
        while (i >= 0 && m[i] == m[6]) begin
            n++;
            i--;
        end
        k  = m[6] ? n - 1 : -n;
        nf = (i > 0) ? i : 0; // Bits below the terminator.
        f  = longint'(m) & ((longint'(1) << nf) - 1);
        v  = (((longint'(1) << nf) + f) << (12 + k)) >>> nf;
        return p[7] ? -v : v;
    endfunction

    function automatic logic [7:0] p8_ref(input logic [1:0] op, input logic [7:0] a,
                                          input logic [7:0] b);
        longint     exact;
        longint     d;
        longint     best_d;
        logic [7:0] best;
        if (a == NAR || b == NAR) begin
            return NAR;
        end
        case (op)
            2'd0:    exact = (posit_value(a) + posit_value(b)) <<< 12;
            2'd1:    exact = (posit_value(a) - posit_value(b)) <<< 12;
            default: exact = posit_value(a) * posit_value(b); // Scale 2^24.
        endcase
        if (exact == 0) begin
            return 8'h00;
        end
        best   = 8'h00;
        best_d = -1;
        // Zero and NaR are never candidates, so saturation falls out of the scan.
        for (int p = 1; p < 256; p++) begin
            if (p != 128) begin
                d = (posit_value(8'(p)) <<< 12) - exact;
                d = (d < 0) ? -d : d;
                if (best_d < 0 || d < best_d || (d == best_d && p[0] == 1'b0)) begin
                    best   = 8'(p);
                    best_d = d;
                end
            end
        end
        return best;
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [7:0] take_bits(input int n);
        logic [7:0] v;
        v = 8'd0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[6:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("CHECKS FAILED");
        $fatal(1, "Run stopped.");
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // AXI4-Lite master.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic write_reg(input logic [3:0] addr, input logic [31:0] value, input int hold,
                             output logic [1:0] resp);
        @(posedge clk);
        #2;
        awaddr  = addr;
        wdata   = value;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = (hold == 0);
        @(negedge clk);
        while (!awready) begin
            @(negedge clk);
        end
        assert (wready) else abort_run("wready did not rise together with awready.");
        @(posedge clk);
        #2;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        @(negedge clk);
        while (!bvalid) begin
            @(negedge clk);
        end
        resp = bresp;
        if (hold > 0) begin
            repeat (hold) @(negedge clk); // Response held back by the master.
            @(posedge clk);
            #2 bready = 1'b1;
            @(posedge clk);
            #2 bready = 1'b0;
        end
    endtask

    task automatic read_reg(input logic [3:0] addr, input int hold, output logic [31:0] data,
                            output logic [1:0] resp);
        @(posedge clk);
        #2;
        araddr  = addr;
        arvalid = 1'b1;
        rready  = (hold == 0);
        @(negedge clk);
        while (!arready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #2 arvalid = 1'b0;
        @(negedge clk);
        while (!rvalid) begin
            @(negedge clk);
        end
        data = rdata;
        resp = rresp;
        if (hold > 0) begin
            repeat (hold) @(negedge clk);
            @(posedge clk);
            #2 rready = 1'b1;
            @(posedge clk);
            #2 rready = 1'b0;
        end
    endtask

    task automatic expect_resp(input string chan, input logic [1:0] got, input logic [1:0] exp);
        assert (got == exp) else
            abort_run($sformatf("Error: %s = 0x%0h, expected 0x%0h", chan, got, exp));
    endtask

    task automatic wait_done(input int hold);
        logic [31:0] data;
        logic [1:0]  resp;
        data = 32'd0;
        while (!data[0]) begin
            read_reg(ADDR_STATUS, hold, data, resp);
            expect_resp("rresp", resp, OKAY);
        end
    endtask

    task automatic collect_result(input logic [1:0] op, input logic [7:0] a,
                                  input logic [7:0] b, input int hold);
        logic [31:0] data;
        logic [1:0]  resp;
        read_reg(ADDR_RESULT, hold, data, resp);
        expect_resp("rresp", resp, OKAY);
        got_q.push_back(data);
        exp_q.push_back(p8_ref(op, a, b));
        tag_q.push_back({op, a, b});
    endtask

    task automatic run_op(input logic [1:0] op, input logic [7:0] a, input logic [7:0] b);
        logic [1:0] resp;
        write_reg(ADDR_OPERANDS, {16'd0, b, a}, 0, resp);
        expect_resp("bresp", resp, OKAY);
        write_reg(ADDR_CTRL, {30'd0, op}, 0, resp);
        expect_resp("bresp", resp, OKAY);
        wait_done(0);
        collect_result(op, a, b, 0);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Compare and timeout.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(negedge clk) begin
        assert (!dut_i.regs_i.props_i.failed) else
            abort_run("A bound AXI or pipeline assertion failed.");
        while (got_q.size() != 0) begin
            got_word = got_q.pop_front();
            exp_z    = exp_q.pop_front();
            tag      = tag_q.pop_front();
            assert (got_word[7:0] == exp_z) else
                abort_run($sformatf(
                    "Error: RESULT.z = 0x%02h, expected 0x%02h (op %0d a %02h b %02h)",
                    got_word[7:0], exp_z, tag[17:16], tag[15:8], tag[7:0]));
            assert (got_word[8] == (exp_z == NAR)) else
                abort_run($sformatf("Error: RESULT.is_nar = 0x%0h, expected 0x%0h",
                                    got_word[8], exp_z == NAR));
            checked++;
        end
    end

    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > CYCLE_LIMIT) begin
                abort_run($sformatf("Timeout: no end of test after %0d cycles.", CYCLE_LIMIT));
            end
        end
    end

    initial begin
        logic [7:0]  a;
        logic [7:0]  b;
        logic [1:0]  op;
        logic [31:0] data;
        logic [31:0] last_result;
        logic [1:0]  resp;
        {awaddr, awvalid, wdata, wvalid, bready} = '0;
        {araddr, arvalid, rready}                = '0;
        arst_n  = 1'b0;
        lfsr    = 32'h7e3e;
        checked = 0;
        repeat (3) @(posedge clk);
        #2 arst_n = 1'b1;

        assert (!awready && !wready && !bvalid && !arready && !rvalid) else
            abort_run("A handshake output was high after reset.");
        read_reg(ADDR_STATUS, 0, data, resp);
        assert (data == 32'd0) else
            abort_run($sformatf("Error: STATUS = 0x%08h, expected 0x0", data));
        read_reg(ADDR_RESULT, 0, data, resp);
        assert (data == 32'd0) else
            abort_run($sformatf("Error: RESULT = 0x%08h, expected 0x0", data));

        for (int i = 0; i < N_DIR; i++) begin
            run_op(DIRECTED[i][17:16], DIRECTED[i][15:8], DIRECTED[i][7:0]);
        end
        for (int i = 0; i < N_RAND; i++) begin
            a  = take_bits(8);
            b  = take_bits(8);
            op = 2'(take_bits(2));
            while (op == 2'd3) begin
                op = 2'(take_bits(2));
            end
            run_op(op, a, b);
        end

        // Error responses. Opcode 3 must leave the last result alone.
        read_reg(ADDR_RESULT, 0, last_result, resp);
        write_reg(4'h2, 32'h0000_1234, 0, resp);
        expect_resp("bresp", resp, SLVERR);
        read_reg(4'hA, 0, data, resp);
        expect_resp("rresp", resp, SLVERR);
        assert (data == 32'd0) else
            abort_run($sformatf("Error: rdata = 0x%08h, expected 0x0", data));
        read_reg(ADDR_CTRL, 0, data, resp);
        expect_resp("rresp", resp, SLVERR);
        write_reg(ADDR_CTRL, 32'd3, 0, resp);
        expect_resp("bresp", resp, SLVERR);
        read_reg(ADDR_STATUS, 0, data, resp);
        assert (data == 32'd1) else
            abort_run($sformatf("Error: STATUS = 0x%08h, expected 0x1", data));
        read_reg(ADDR_RESULT, 0, data, resp);
        assert (data == last_result) else
            abort_run($sformatf("Error: RESULT = 0x%08h, expected 0x%08h", data, last_result));

        // Two launches back to back under back-pressure.
        write_reg(ADDR_OPERANDS, {16'd0, 8'h4B, 8'h2D}, 0, resp);
        write_reg(ADDR_CTRL, {30'd0, OP_ADD}, 0, resp);
        expect_resp("bresp", resp, OKAY);
        write_reg(ADDR_CTRL, {30'd0, OP_MUL}, 6, resp);
        expect_resp("bresp", resp, OKAY);
        wait_done(4);
        collect_result(OP_MUL, 8'h2D, 8'h4B, 4);

        repeat (3) @(posedge clk);
        if (got_q.size() == 0 && checked == N_CHECKED) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("Only %0d of %0d results were compared.", checked, N_CHECKED);
            $display("CHECKS FAILED");
            $fatal(1, "Run stopped.");
        end
    end

endmodule

/* list.f */
p8e0_pkg.sv
p8e0_add.sv
p8e0_mul.sv
p8e0_alu.sv
p8e0_axil_regs.sv
p8e0_top.sv
p8e0_properties.sv
tb_p8e0_top.sv
